//--- hw/yuv420_defs.svh
`ifndef YUV420_DEFS_SVH
`define YUV420_DEFS_SVH

// width of one y, u or v channel
`define YUV_PIX_WIDTH 8

// width of a packed output word
`define YUV_WORD_WIDTH 32

// header payload and image_type width
`define YUV_META_WIDTH 16

// packing buffer holds one full word plus one y/u/v triple
`define YUV_OBUF_WIDTH 56

// fill count of the packing buffer in bits
`define YUV_POS_WIDTH 6

// column counter and line buffer address width
`define YUV_COL_WIDTH 11

// deepest row the line buffer can hold
`define YUV_MAX_COLS 1288

// header half-word that carries image_type in place of meta data
`define YUV_IMAGE_TYPE_SLOT 3

`endif

//--- hw/yuv420_pkg.sv
`include "yuv420_defs.svh"

package yuv420_pkg;

   // type tag of every word on the input and output streams
   // zero is left unused so an idle bus after reset reads as no type
   typedef enum logic [3:0] {
      frame_start  = 4'd1,
      frame_end    = 4'd2,
      row_start    = 4'd3,
      row_end      = 4'd4,
      pixel        = 4'd5,
      header_start = 4'd6,
      header       = 4'd7
   } dtype_t;

   // one chroma sample pair as stored in the line buffer
   // u sits in the upper byte
   typedef struct packed {
      logic [`YUV_PIX_WIDTH-1:0] u;
      logic [`YUV_PIX_WIDTH-1:0] v;
   } uv_pair_t;

endpackage

//--- hw/uv_line_mem.sv
`include "yuv420_defs.svh"

module uv_line_mem (
   input  logic                      clk,
   input  logic [`YUV_COL_WIDTH-1:0] addr,
   input  logic                      we,
   input  yuv420_pkg::uv_pair_t      wdata,
   output yuv420_pkg::uv_pair_t      rdata
);

   // one entry per column of the previous row
   yuv420_pkg::uv_pair_t mem [0:`YUV_MAX_COLS-1];

   // single port with read-before-write
   // rdata returns the pair that was stored before this write
   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= wdata;
      end
      rdata <= mem[addr];
   end

endmodule

//--- hw/uv_block_avg.sv
`include "yuv420_defs.svh"

module uv_block_avg (
   input  logic                       clk,
   input  logic                       resetb,
   input  logic                       dvi,
   input  yuv420_pkg::dtype_t         dtypei,
   input  logic [`YUV_PIX_WIDTH-1:0]  yi,
   input  logic [`YUV_PIX_WIDTH-1:0]  ui,
   input  logic [`YUV_PIX_WIDTH-1:0]  vi,
   input  logic [`YUV_META_WIDTH-1:0] meta_datai,
   output logic                       dv_d,
   output yuv420_pkg::dtype_t         dtype_d,
   output logic [`YUV_PIX_WIDTH-1:0]  y_d,
   output logic [`YUV_PIX_WIDTH-1:0]  u_d,
   output logic [`YUV_PIX_WIDTH-1:0]  v_d,
   output logic [`YUV_META_WIDTH-1:0] meta_d,
   output logic [`YUV_PIX_WIDTH-1:0]  u_avg,
   output logic [`YUV_PIX_WIDTH-1:0]  v_avg,
   output logic                       dump_uv
);

   // input side word decode
   logic pix_in;
   assign pix_in = dvi && (dtypei == yuv420_pkg::pixel);

   // column of the incoming pixel, also the line buffer address
   logic [`YUV_COL_WIDTH-1:0] col;
   // high on odd rows of the frame
   logic row_phase;

   // chroma of the incoming pixel goes into the line buffer
   yuv420_pkg::uv_pair_t wr_pair;
   // same column of the row above, aligned with the delayed stream
   yuv420_pkg::uv_pair_t above_pair;
   // left neighbours in the current row and in the row above
   yuv420_pkg::uv_pair_t left_pair;
   yuv420_pkg::uv_pair_t left_above;

   assign wr_pair = '{u: ui, v: vi};

   uv_line_mem u_line_mem (
      .clk   (clk),
      .addr  (col),
      .we    (pix_in),
      .wdata (wr_pair),
      .rdata (above_pair)
   );

   // position tracking on the input side
   // row_end toggles the phase after the last pixel of the row has
   // already been sampled, so the delayed stream sees a stable phase
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         col       <= '0;
         row_phase <= 1'b0;
      end else if (dvi) begin
         if (dtypei == yuv420_pkg::row_start) begin
            col <= '0;
         end else if (dtypei == yuv420_pkg::pixel) begin
            col <= col + 1'b1;
         end
         if (dtypei == yuv420_pkg::frame_start) begin
            row_phase <= 1'b0;
         end else if (dtypei == yuv420_pkg::row_end) begin
            row_phase <= ~row_phase;
         end
      end
   end

   // control part of the one cycle stream delay
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         dv_d    <= 1'b0;
         dtype_d <= yuv420_pkg::dtype_t'(0);
         dump_uv <= 1'b0;
      end else begin
         dv_d    <= dvi;
         dtype_d <= dtypei;
         // bottom right pixel of a 2x2 block
         dump_uv <= pix_in && row_phase && col[0];
      end
   end

   // payload part of the delay
   always_ff @(posedge clk) begin
      y_d    <= yi;
      u_d    <= ui;
      v_d    <= vi;
      meta_d <= meta_datai;
   end

   // keep the previous pixel of both rows for the left half of the block
   always_ff @(posedge clk) begin
      if (dv_d && (dtype_d == yuv420_pkg::pixel)) begin
         left_pair  <= '{u: u_d, v: v_d};
         left_above <= above_pair;
      end
   end

   // four byte sums with two guard bits
   logic [`YUV_PIX_WIDTH+1:0] u_sum;
   logic [`YUV_PIX_WIDTH+1:0] v_sum;

   assign u_sum = {2'b00, left_above.u} + {2'b00, above_pair.u}
                + {2'b00, left_pair.u} + {2'b00, u_d};
   assign v_sum = {2'b00, left_above.v} + {2'b00, above_pair.v}
                + {2'b00, left_pair.v} + {2'b00, v_d};

   // drop two lsbs for the floor of sum / 4
   assign u_avg = u_sum[`YUV_PIX_WIDTH+1:2];
   assign v_avg = v_sum[`YUV_PIX_WIDTH+1:2];

endmodule

//--- hw/byte_packer.sv
`include "yuv420_defs.svh"

module byte_packer (
   input  logic                       clk,
   input  logic                       resetb,
   input  logic                       enable_yuv420,
   input  logic [`YUV_META_WIDTH-1:0] image_type,
   input  logic                       dv_d,
   input  yuv420_pkg::dtype_t         dtype_d,
   input  logic [`YUV_PIX_WIDTH-1:0]  y_d,
   input  logic [`YUV_PIX_WIDTH-1:0]  u_d,
   input  logic [`YUV_PIX_WIDTH-1:0]  v_d,
   input  logic [`YUV_META_WIDTH-1:0] meta_d,
   input  logic [`YUV_PIX_WIDTH-1:0]  u_avg,
   input  logic [`YUV_PIX_WIDTH-1:0]  v_avg,
   input  logic                       dump_uv,
   output logic                       dvo,
   output yuv420_pkg::dtype_t         dtypeo,
   output logic [`YUV_WORD_WIDTH-1:0] datao
);

   localparam int OBW = `YUV_OBUF_WIDTH;
   localparam int PW  = `YUV_PIX_WIDTH;
   localparam logic [`YUV_POS_WIDTH-1:0] WORD_BITS = `YUV_POS_WIDTH'(`YUV_WORD_WIDTH);
   localparam logic [`YUV_POS_WIDTH-1:0] ONE_BYTE  = `YUV_POS_WIDTH'(PW);
   localparam logic [`YUV_POS_WIDTH-1:0] TRIPLE    = `YUV_POS_WIDTH'(3 * PW);
   localparam logic [`YUV_POS_WIDTH-1:0] TYPE_SLOT =
      `YUV_POS_WIDTH'(`YUV_IMAGE_TYPE_SLOT);

   // newest byte enters at the bottom
   // opos counts the valid bits
   // opos doubles as the half-word index while a header is running
   logic [OBW-1:0]            obuf;
   logic [`YUV_POS_WIDTH-1:0] opos;
   // frame_end marker owed behind last cycle's flush word
   logic                      flushed;

   logic pix_in;
   logic hdr_in;
   logic flush_required;

   assign pix_in         = dv_d && (dtype_d == yuv420_pkg::pixel);
   assign hdr_in         = dv_d && (dtype_d == yuv420_pkg::header);
   assign flush_required = dv_d && (dtype_d == yuv420_pkg::frame_end) && (opos != '0);

   logic [OBW-1:0]            next_obuf;
   logic [`YUV_POS_WIDTH-1:0] next_opos;

   always_comb begin
      if (flush_required) begin
         // push leftovers up to the word boundary with zeros below
         next_obuf = obuf << (WORD_BITS - opos);
         next_opos = WORD_BITS;
      end else if (!enable_yuv420) begin
         // pass mode keeps all three channels
         next_obuf = {obuf[OBW-3*PW-1:0], y_d, u_d, v_d};
         next_opos = opos + TRIPLE;
      end else if (dump_uv) begin
         // odd row and odd column adds the block averages
         next_obuf = {obuf[OBW-3*PW-1:0], y_d, u_avg, v_avg};
         next_opos = opos + TRIPLE;
      end else begin
         // luma only
         next_obuf = {obuf[OBW-PW-1:0], y_d};
         next_opos = opos + ONE_BYTE;
      end
   end

   // bits left over once a word is taken out
   logic [`YUV_POS_WIDTH-1:0] next_opos2;
   logic [OBW-1:0]            shifted;
   logic [`YUV_WORD_WIDTH-1:0] word;

   assign next_opos2 = next_opos - WORD_BITS;
   assign shifted    = next_obuf >> next_opos2;
   // oldest byte sits in word[31:24] here
   assign word       = shifted[`YUV_WORD_WIDTH-1:0];

   // header half after image_type substitution
   logic [`YUV_META_WIDTH-1:0] meta_sel;
   assign meta_sel = (opos == TYPE_SLOT) ? image_type : meta_d;

   // packing buffer loads only on pixels and flushes
   always_ff @(posedge clk) begin
      if (pix_in || flush_required) begin
         obuf <= next_obuf;
      end
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         dvo     <= 1'b0;
         dtypeo  <= yuv420_pkg::dtype_t'(0);
         datao   <= '0;
         opos    <= '0;
         flushed <= 1'b0;
      end else begin
         flushed <= flush_required;

         if (pix_in || flush_required) begin
            dtypeo <= yuv420_pkg::pixel;
            if (next_opos >= WORD_BITS) begin
               dvo <= 1'b1;
               // byte swap so the oldest byte lands in bits 7:0
               datao <= {word[PW-1:0], word[2*PW-1:PW],
                         word[3*PW-1:2*PW], word[4*PW-1:3*PW]};
               opos  <= next_opos2;
            end else begin
               dvo  <= 1'b0;
               opos <= next_opos;
            end
         end else if (flushed) begin
            // the frame_end held back behind the flush word
            dvo    <= 1'b1;
            dtypeo <= yuv420_pkg::frame_end;
            datao  <= '0;
         end else if (hdr_in) begin
            dtypeo <= yuv420_pkg::header;
            opos   <= opos + 1'b1;
            // two halves per word, low half first
            if (opos[0]) begin
               datao[`YUV_WORD_WIDTH-1:`YUV_META_WIDTH] <= meta_sel;
               dvo <= 1'b1;
            end else begin
               datao[`YUV_META_WIDTH-1:0] <= meta_sel;
               dvo <= 1'b0;
            end
         end else if (dv_d) begin
            // markers pass through with an empty payload
            dvo    <= 1'b1;
            dtypeo <= dtype_d;
            datao  <= '0;
            if ((dtype_d == yuv420_pkg::frame_start) ||
                (dtype_d == yuv420_pkg::header_start)) begin
               opos <= '0;
            end
         end else begin
            // type and data hold their last values while idle
            dvo <= 1'b0;
         end
      end
   end

endmodule

//--- hw/yuv420_top.sv
`include "yuv420_defs.svh"

module yuv420_top (
   input  logic                       clk,
   input  logic                       resetb,
   input  logic                       enable_yuv420,
   input  logic [`YUV_META_WIDTH-1:0] image_type,
   input  logic                       dvi,
   input  yuv420_pkg::dtype_t         dtypei,
   input  logic [`YUV_PIX_WIDTH-1:0]  yi,
   input  logic [`YUV_PIX_WIDTH-1:0]  ui,
   input  logic [`YUV_PIX_WIDTH-1:0]  vi,
   input  logic [`YUV_META_WIDTH-1:0] meta_datai,
   output logic                       dvo,
   output yuv420_pkg::dtype_t         dtypeo,
   output logic [`YUV_WORD_WIDTH-1:0] datao
);

   // stream delayed by the averaging stage
   logic                       dv_d;
   yuv420_pkg::dtype_t         dtype_d;
   logic [`YUV_PIX_WIDTH-1:0]  y_d;
   logic [`YUV_PIX_WIDTH-1:0]  u_d;
   logic [`YUV_PIX_WIDTH-1:0]  v_d;
   logic [`YUV_META_WIDTH-1:0] meta_d;
   // 2x2 chroma averages and when to use them
   logic [`YUV_PIX_WIDTH-1:0]  u_avg;
   logic [`YUV_PIX_WIDTH-1:0]  v_avg;
   logic                       dump_uv;

   uv_block_avg u_block_avg (
      .clk        (clk),
      .resetb     (resetb),
      .dvi        (dvi),
      .dtypei     (dtypei),
      .yi         (yi),
      .ui         (ui),
      .vi         (vi),
      .meta_datai (meta_datai),
      .dv_d       (dv_d),
      .dtype_d    (dtype_d),
      .y_d        (y_d),
      .u_d        (u_d),
      .v_d        (v_d),
      .meta_d     (meta_d),
      .u_avg      (u_avg),
      .v_avg      (v_avg),
      .dump_uv    (dump_uv)
   );

   byte_packer u_packer (
      .clk           (clk),
      .resetb        (resetb),
      .enable_yuv420 (enable_yuv420),
      .image_type    (image_type),
      .dv_d          (dv_d),
      .dtype_d       (dtype_d),
      .y_d           (y_d),
      .u_d           (u_d),
      .v_d           (v_d),
      .meta_d        (meta_d),
      .u_avg         (u_avg),
      .v_avg         (v_avg),
      .dump_uv       (dump_uv),
      .dvo           (dvo),
      .dtypeo        (dtypeo),
      .datao         (datao)
   );

endmodule

//--- sim/yuv420_sva.sv
`include "yuv420_defs.svh"

module yuv420_sva (
   input logic                       clk,
   input logic                       resetb,
   input logic                       dvi,
   input yuv420_pkg::dtype_t         dtypei,
   input logic                       dvo,
   input yuv420_pkg::dtype_t         dtypeo,
   input logic [`YUV_WORD_WIDTH-1:0] datao
);

   timeunit 1ns;
   timeprecision 100ps;

   // row and frame markers that always pass straight through
   logic marker_in;
   assign marker_in = dvi && ((dtypei == yuv420_pkg::row_start) ||
                              (dtypei == yuv420_pkg::row_end) ||
                              (dtypei == yuv420_pkg::frame_start));

   // output stays quiet right after reset
   assert property (@(posedge clk) $rose(resetb) |-> !dvo)
      else $error("dvo high in the first cycle after reset");

   // two cycle latency through averaging stage and packer
   assert property (@(posedge clk) disable iff (!resetb)
                    marker_in |-> ##2 (dvo && (dtypeo == $past(dtypei, 2))))
      else $error("marker did not reach dvo two cycles after dvi");

   // row markers carry no payload
   assert property (@(posedge clk) disable iff (!resetb)
                    ((dtypeo == yuv420_pkg::row_start) ||
                     (dtypeo == yuv420_pkg::row_end)) |-> (datao == '0))
      else $error("nonzero datao on a row marker");

endmodule

bind yuv420_top yuv420_sva u_sva (.*);

//--- sim/yuv420_tb.sv
`include "yuv420_defs.svh"

module yuv420_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int NUM_FRAMES = 8;
   localparam int MAX_ROWS   = 12;
   localparam int MAX_COLS   = 40;

   typedef logic [`YUV_PIX_WIDTH-1:0] plane_t [0:MAX_ROWS-1][0:MAX_COLS-1];
   typedef logic [`YUV_META_WIDTH-1:0] hdr_t [0:7];
   // word type in the upper nibble over the 32-bit data
   typedef logic [35:0] word_q_t [$];

   logic                       clk = 1'b0;
   logic                       resetb;
   logic                       enable_yuv420;
   logic [`YUV_META_WIDTH-1:0] image_type;
   logic                       dvi;
   yuv420_pkg::dtype_t         dtypei;
   logic [`YUV_PIX_WIDTH-1:0]  yi;
   logic [`YUV_PIX_WIDTH-1:0]  ui;
   logic [`YUV_PIX_WIDTH-1:0]  vi;
   logic [`YUV_META_WIDTH-1:0] meta_datai;
   logic                       dvo;
   yuv420_pkg::dtype_t         dtypeo;
   logic [`YUV_WORD_WIDTH-1:0] datao;

   // words still owed by the DUT, oldest first
   logic [35:0] exp_q [$];
   int          errors = 0;
   int          limit_cycles = 0;
   int          f_cols [0:NUM_FRAMES-1];
   int          f_rows [0:NUM_FRAMES-1];
   logic        f_mode [0:NUM_FRAMES-1];

   yuv420_top i_dut (
      .clk           (clk),
      .resetb        (resetb),
      .enable_yuv420 (enable_yuv420),
      .image_type    (image_type),
      .dvi           (dvi),
      .dtypei        (dtypei),
      .yi            (yi),
      .ui            (ui),
      .vi            (vi),
      .meta_datai    (meta_datai),
      .dvo           (dvo),
      .dtypeo        (dtypeo),
      .datao         (datao)
   );

   // 4 ns period
   always #2 clk = ~clk;

   function automatic int pick_between(input int lo, input int hi);
      return lo + int'($urandom % (hi - lo + 1));
   endfunction

   // output words of one frame and its header in stream order
   function automatic word_q_t expected_words(input plane_t py, input plane_t pu,
                                              input plane_t pv, input int cols,
                                              input int rows, input logic yuv420,
                                              input hdr_t hdr, input logic [15:0] itype);
      word_q_t    q;
      logic [7:0] bytes [$];
      logic [15:0] lo;
      logic [15:0] hi;
      logic [31:0] w;
      int          su;
      int          sv;
      q.push_back({yuv420_pkg::header_start, 32'h0});
      // two halves per word with image_type in its slot
      for (int k = 0; k < 4; k++) begin
         lo = (2 * k == `YUV_IMAGE_TYPE_SLOT) ? itype : hdr[2 * k];
         hi = (2 * k + 1 == `YUV_IMAGE_TYPE_SLOT) ? itype : hdr[2 * k + 1];
         q.push_back({yuv420_pkg::header, hi, lo});
      end
      q.push_back({yuv420_pkg::frame_start, 32'h0});
      for (int r = 0; r < rows; r++) begin
         q.push_back({yuv420_pkg::row_start, 32'h0});
         for (int c = 0; c < cols; c++) begin
            bytes.push_back(py[r][c]);
            if (!yuv420) begin
               bytes.push_back(pu[r][c]);
               bytes.push_back(pv[r][c]);
            end else if ((r % 2 == 1) && (c % 2 == 1)) begin
               // floor mean of the 2x2 block ending here
               su = pu[r-1][c-1] + pu[r-1][c] + pu[r][c-1] + pu[r][c];
               sv = pv[r-1][c-1] + pv[r-1][c] + pv[r][c-1] + pv[r][c];
               bytes.push_back(8'(su / 4));
               bytes.push_back(8'(sv / 4));
            end
            if (bytes.size() >= 4) begin
               w = {bytes[3], bytes[2], bytes[1], bytes[0]};
               repeat (4) void'(bytes.pop_front());
               q.push_back({yuv420_pkg::pixel, w});
            end
         end
         q.push_back({yuv420_pkg::row_end, 32'h0});
      end
      // leftovers zero padded at the top
      if (bytes.size() > 0) begin
         while (bytes.size() < 4) bytes.push_back(8'h00);
         q.push_back({yuv420_pkg::pixel, bytes[3], bytes[2], bytes[1], bytes[0]});
      end
      q.push_back({yuv420_pkg::frame_end, 32'h0});
      return q;
   endfunction

   task automatic drive_word(input yuv420_pkg::dtype_t t, input logic [7:0] y,
                             input logic [7:0] u, input logic [7:0] v,
                             input logic [15:0] m);
      @(posedge clk);
      #0.5;
      dvi        = 1'b1;
      dtypei     = t;
      yi         = y;
      ui         = u;
      vi         = v;
      meta_datai = m;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #0.5;
         dvi = 1'b0;
      end
   endtask

   initial begin : stimulus
      plane_t      py;
      plane_t      pu;
      plane_t      pv;
      hdr_t        hdr;
      word_q_t     ew;
      logic [15:0] itype;
      int          total;
      int          waited;
      resetb        = 1'b0;
      enable_yuv420 = 1'b1;
      image_type    = '0;
      dvi           = 1'b0;
      dtypei        = yuv420_pkg::dtype_t'(0);
      yi            = '0;
      ui            = '0;
      vi            = '0;
      meta_datai    = '0;
      void'($urandom(58));
      // fixed sizes on some frames cover the even and the flush cases
      for (int f = 0; f < NUM_FRAMES; f++) begin
         f_cols[f] = pick_between(2, MAX_COLS);
         f_rows[f] = pick_between(2, MAX_ROWS);
         f_mode[f] = !((f == 5) || (f == 6));
      end
      f_cols[0] = 8;
      f_rows[0] = 2;
      f_cols[1] = 5;
      f_rows[1] = 3;
      f_cols[2] = pick_between(1, 19) * 2 + 1;
      f_cols[3] = pick_between(1, 20) * 2;
      f_cols[5] = 4;
      f_rows[5] = 2;
      total = 0;
      for (int f = 0; f < NUM_FRAMES; f++) begin
         total += 12 + f_rows[f] * (f_cols[f] + 2);
      end
      limit_cycles = total * 4 + 200;

      repeat (2) @(posedge clk);
      #0.5;
      resetb = 1'b1;
      @(negedge clk);
      assert ((dvo === 1'b0) && (dtypeo === 4'h0) && (datao === '0)) else begin
         $display("Fail dvo/dtypeo/datao after reset: %0h %0h %08h", dvo, dtypeo, datao);
         errors++;
      end

      for (int f = 0; f < NUM_FRAMES; f++) begin
         for (int r = 0; r < f_rows[f]; r++) begin
            for (int c = 0; c < f_cols[f]; c++) begin
               py[r][c] = 8'($urandom);
               pu[r][c] = 8'($urandom);
               pv[r][c] = 8'($urandom);
            end
         end
         for (int k = 0; k < 8; k++) hdr[k] = 16'($urandom);
         itype = 16'($urandom);
         ew = expected_words(py, pu, pv, f_cols[f], f_rows[f], f_mode[f], hdr, itype);
         foreach (ew[i]) exp_q.push_back(ew[i]);
         // static controls change only between frames
         enable_yuv420 = f_mode[f];
         image_type    = itype;
         drive_word(yuv420_pkg::header_start, 8'h0, 8'h0, 8'h0, 16'h0);
         idle_cycles(pick_between(0, 2));
         for (int k = 0; k < 8; k++) begin
            drive_word(yuv420_pkg::header, 8'h0, 8'h0, 8'h0, hdr[k]);
            idle_cycles(pick_between(0, 2));
         end
         drive_word(yuv420_pkg::frame_start, 8'h0, 8'h0, 8'h0, 16'h0);
         for (int r = 0; r < f_rows[f]; r++) begin
            drive_word(yuv420_pkg::row_start, 8'h0, 8'h0, 8'h0, 16'h0);
            for (int c = 0; c < f_cols[f]; c++) begin
               drive_word(yuv420_pkg::pixel, py[r][c], pu[r][c], pv[r][c], 16'h0);
               idle_cycles(pick_between(0, 2));
            end
            drive_word(yuv420_pkg::row_end, 8'h0, 8'h0, 8'h0, 16'h0);
            idle_cycles(pick_between(0, 2));
         end
         drive_word(yuv420_pkg::frame_end, 8'h0, 8'h0, 8'h0, 16'h0);
         // a pending flush needs one free cycle behind frame_end
         idle_cycles(1 + pick_between(0, 2));
      end

      waited = 0;
      while ((exp_q.size() != 0) && (waited < 100)) begin
         @(posedge clk);
         waited++;
      end
      // give stray words a chance to show up
      repeat (10) @(posedge clk);
      if (exp_q.size() != 0) begin
         $display("missing output: %0d expected words never arrived", exp_q.size());
         errors++;
      end
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

   // registered outputs are compared on the falling edge
   always @(negedge clk) begin : compare
      logic [35:0] exp_e;
      if (resetb && dvo) begin
         if (exp_q.size() == 0) begin
            $display("unexpected output word of type %0h data %08h", dtypeo, datao);
            errors++;
         end else begin
            exp_e = exp_q.pop_front();
            assert (dtypeo === exp_e[35:32]) else begin
               $display("Fail dtypeo: got %0h expected %0h", dtypeo, exp_e[35:32]);
               errors++;
            end
            assert (datao === exp_e[31:0]) else begin
               $display("Fail datao: got %08h expected %08h", datao, exp_e[31:0]);
               errors++;
            end
         end
      end
   end

   initial begin : watchdog
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge clk);
      $display("timeout: no end of run after %0d cycles", limit_cycles);
      $display("errors: %0d", errors + 1);
      $display("TEST FAIL");
      $finish;
   end

endmodule

//--- src.f
+incdir+hw
hw/yuv420_pkg.sv
hw/uv_line_mem.sv
hw/uv_block_avg.sv
hw/byte_packer.sv
hw/yuv420_top.sv
sim/yuv420_sva.sv
sim/yuv420_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = yuv420_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir

SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(filter-out +%,$(shell cat $(FILELIST))) hw/yuv420_defs.svh

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
